// ==== hw/ising_settings.svh ====
/*
 * Problem size and datapath widths of the Ising energy engine.
 * NUM_SPIN must be a multiple of PARALLELISM.
 * ENERGY_BIT must hold NUM_SPIN*NUM_SPIN*2^(BITJ-1) plus the h term.
 */
`ifndef ISING_SETTINGS_SVH
`define ISING_SETTINGS_SVH

// number of spins in one configuration
`define ISING_NUM_SPIN 16

// signed J and h entry width
`define ISING_BITJ 4

// J rows per memory word
`define ISING_PARALLELISM 2

// signed energy width
`define ISING_ENERGY_BIT 24

`endif

// ==== hw/ising_pkg.sv ====
/*
 * Types of the Ising problem: spins, couplings, biases and energies.
 * Sizes come from the settings header.
 * A set spin bit means +1, a clear bit means -1.
 */
`include "ising_settings.svh"

package ising_pkg;

    localparam int NUM_SPIN    = `ISING_NUM_SPIN;
    localparam int BITJ        = `ISING_BITJ;
    localparam int PARALLELISM = `ISING_PARALLELISM;
    localparam int ENERGY_BIT  = `ISING_ENERGY_BIT;

    // memory words per full matrix
    localparam int J_WORDS    = NUM_SPIN / PARALLELISM;
    localparam int J_ADDR_BIT = (J_WORDS > 1) ? $clog2(J_WORDS) : 1;

    typedef logic [NUM_SPIN-1:0] spin_vec_t;

    typedef logic signed [BITJ-1:0] weight_t;

    // entry j of a row sits at bits [j*BITJ +: BITJ]
    typedef weight_t [NUM_SPIN-1:0] j_row_t;

    // row 0 of the word in the low bits
    typedef j_row_t [PARALLELISM-1:0] j_word_t;

    typedef weight_t [NUM_SPIN-1:0] hbias_vec_t;

    typedef logic signed [ENERGY_BIT-1:0] energy_t;

    typedef logic [J_ADDR_BIT-1:0] j_addr_t;

endpackage

// ==== hw/pipe_pkg.sv ====
/*
 * Payloads passed between the pipeline stages.
 * Each travels with a separate one-cycle valid strobe and
 * there is no back-pressure between stages.
 */
package pipe_pkg;

    import ising_pkg::*;

    // decode to execute, one per memory read
    typedef struct packed {
        spin_vec_t spin;
        j_addr_t   addr;
        logic      last;
    } fetch_cmd_t;

    // execute to result, one per finished configuration
    typedef struct packed {
        energy_t   energy;
        spin_vec_t spin;
    } energy_result_t;

endpackage

// ==== hw/weight_fetch.sv ====
/*
 * Decode stage. Takes one spin vector per handshake and reads all
 * J_WORDS words of J in order, one per cycle.
 * Only one configuration is in flight; ready stays low until the
 * accumulator reports its result or a flush arrives.
 */
`timescale 1ns/1ps

module weight_fetch
    import ising_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       flush_i,
    input  logic       spin_valid_i,
    input  spin_vec_t  spin_i,
    output logic       spin_ready_o,
    input  logic       busy_release_i,
    output logic       j_ren_o,
    output j_addr_t    j_raddr_o,
    output logic       cmd_valid_o,
    output fetch_cmd_t cmd_o
);

    logic      busy_q;
    logic      fetching_q;
    j_addr_t   addr_q;
    spin_vec_t spin_q;
    logic      last_word;
    logic      spin_hs;

    // ready comes back together with the result strobe
    assign spin_ready_o = ~busy_q | busy_release_i;
    assign spin_hs      = spin_valid_i & spin_ready_o;
    assign last_word    = (addr_q == j_addr_t'(J_WORDS - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            busy_q     <= 1'b0;
            fetching_q <= 1'b0;
            addr_q     <= '0;
        end else if (spin_hs) begin
            busy_q     <= 1'b1;
            fetching_q <= 1'b1;
            addr_q     <= '0;
        end else begin
            if (busy_release_i) begin
                busy_q <= 1'b0;
            end
            if (fetching_q) begin
                addr_q <= last_word ? '0 : addr_q + 1'b1;
                if (last_word) begin
                    fetching_q <= 1'b0;
                end
            end
        end
    end

    // payload, held for the whole computation
    always_ff @(posedge clk_i) begin
        if (spin_hs) begin
            spin_q <= spin_i;
        end
    end

    assign j_ren_o   = fetching_q;
    assign j_raddr_o = addr_q;

    assign cmd_valid_o = fetching_q;
    assign cmd_o.spin  = spin_q;
    assign cmd_o.addr  = addr_q;
    assign cmd_o.last  = last_word;

endmodule

// ==== hw/energy_accumulator.sv ====
/*
 * Execute stage. Each returned J word holds PARALLELISM rows; row i adds
 * sigma_i * (sum_j J[i][j]*sigma_j + h[i]) to the running energy.
 * The command is delayed one cycle to meet the one-cycle memory latency.
 * hbias_i must stay stable during a computation.
 */
`timescale 1ns/1ps

module energy_accumulator
    import ising_pkg::*;
    import pipe_pkg::*;
(
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           flush_i,
    input  logic           cmd_valid_i,
    input  fetch_cmd_t     cmd_i,
    input  j_word_t        j_rdata_i,
    input  hbias_vec_t     hbias_i,
    output logic           result_valid_o,
    output energy_result_t result_o
);

    logic       cmd_valid_q;
    fetch_cmd_t cmd_q;
    energy_t    acc_q;
    energy_t    word_sum;
    energy_t    acc_base;
    energy_t    acc_next;

    // line the command up with the returning data
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= cmd_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_valid_i) begin
            cmd_q <= cmd_i;
        end
    end

    // contribution of all rows in the current word
    always_comb begin
        energy_t row_sum;
        energy_t j_ext;
        int      row_idx;

        word_sum = '0;
        for (int p = 0; p < PARALLELISM; p++) begin
            row_idx = int'(cmd_q.addr) * PARALLELISM + p;
            row_sum = energy_t'($signed(hbias_i[row_idx]));
            for (int j = 0; j < NUM_SPIN; j++) begin
                j_ext = energy_t'($signed(j_rdata_i[p][j]));
                if (cmd_q.spin[j]) begin
                    row_sum = row_sum + j_ext;
                end else begin
                    row_sum = row_sum - j_ext;
                end
            end
            // row's own spin sign
            if (cmd_q.spin[row_idx]) begin
                word_sum = word_sum + row_sum;
            end else begin
                word_sum = word_sum - row_sum;
            end
        end
    end

    // word 0 starts a fresh sum
    assign acc_base = (cmd_q.addr == '0) ? energy_t'(0) : acc_q;
    assign acc_next = acc_base + word_sum;

    always_ff @(posedge clk_i) begin
        if (cmd_valid_q) begin
            acc_q <= acc_next;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= cmd_valid_q & cmd_q.last;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_valid_q && cmd_q.last) begin
            result_o.energy <= acc_next;
            result_o.spin   <= cmd_q.spin;
        end
    end

endmodule

// ==== hw/best_spin_tracker.sv ====
/*
 * Result stage. Keeps the lowest energy seen and its spin vector.
 * With en_comparison_i low every result overwrites the store.
 * Ties keep the older entry. flush_i empties the store.
 */
`timescale 1ns/1ps

module best_spin_tracker
    import ising_pkg::*;
    import pipe_pkg::*;
(
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           flush_i,
    input  logic           en_comparison_i,
    input  logic           result_valid_i,
    input  energy_result_t result_i,
    output logic           best_update_o,
    output logic           best_valid_o,
    output energy_t        best_energy_o,
    output spin_vec_t      best_spin_o
);

    logic    is_lower;
    logic    take_result;
    energy_t new_energy;

    assign new_energy = result_i.energy;
    assign is_lower   = (new_energy < best_energy_o);

    // empty store or comparison off always accepts
    assign take_result = result_valid_i &
                         (~best_valid_o | is_lower | ~en_comparison_i);

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            best_valid_o  <= 1'b0;
            best_update_o <= 1'b0;
        end else begin
            best_update_o <= take_result;
            if (take_result) begin
                best_valid_o <= 1'b1;
            end
        end
    end

    // stored best, qualified by best_valid_o
    always_ff @(posedge clk_i) begin
        if (take_result && !flush_i) begin
            best_energy_o <= new_energy;
            best_spin_o   <= result_i.spin;
        end
    end

endmodule

// ==== hw/ising_macro_top.sv ====
/*
 * Ising energy engine top level.
 * J memory must answer j_ren_o with j_rdata_i exactly one cycle later.
 * hbias_i and en_comparison_i are held stable during a computation.
 * energy_valid_o follows the spin handshake by J_WORDS+2 cycles.
 */
`timescale 1ns/1ps

module ising_macro_top
    import ising_pkg::*;
    import pipe_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       flush_i,
    input  logic       spin_valid_i,
    input  spin_vec_t  spin_i,
    output logic       spin_ready_o,
    output logic       j_ren_o,
    output j_addr_t    j_raddr_o,
    input  j_word_t    j_rdata_i,
    input  hbias_vec_t hbias_i,
    input  logic       en_comparison_i,
    output logic       energy_valid_o,
    output energy_t    energy_o,
    output logic       best_update_o,
    output logic       best_valid_o,
    output energy_t    best_energy_o,
    output spin_vec_t  best_spin_o
);

    logic           cmd_valid;
    fetch_cmd_t     cmd;
    logic           result_valid;
    energy_result_t result;

    weight_fetch weight_fetch_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .spin_valid_i   (spin_valid_i),
        .spin_i         (spin_i),
        .spin_ready_o   (spin_ready_o),
        .busy_release_i (result_valid),
        .j_ren_o        (j_ren_o),
        .j_raddr_o      (j_raddr_o),
        .cmd_valid_o    (cmd_valid),
        .cmd_o          (cmd)
    );

    energy_accumulator energy_accumulator_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .cmd_valid_i    (cmd_valid),
        .cmd_i          (cmd),
        .j_rdata_i      (j_rdata_i),
        .hbias_i        (hbias_i),
        .result_valid_o (result_valid),
        .result_o       (result)
    );

    best_spin_tracker best_spin_tracker_inst (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .flush_i         (flush_i),
        .en_comparison_i (en_comparison_i),
        .result_valid_i  (result_valid),
        .result_i        (result),
        .best_update_o   (best_update_o),
        .best_valid_o    (best_valid_o),
        .best_energy_o   (best_energy_o),
        .best_spin_o     (best_spin_o)
    );

    assign energy_valid_o = result_valid;
    assign energy_o       = result.energy;

endmodule

// ==== sim/ising_checker.sv ====
/*
 * Protocol assertions for the Ising engine top level.
 * Bound into ising_macro_top, so its inputs carry the DUT's own outputs.
 * Properties are not evaluated while reset_i is high.
 */
`timescale 1ns/1ps

module ising_checker (
    input logic clk_i,
    input logic reset_i,
    input logic flush_i,
    input logic spin_ready_i,
    input logic j_ren_i,
    input logic energy_valid_i,
    input logic best_update_i,
    input logic best_valid_i
);

    // memory reads only while busy
    ren_not_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        !(j_ren_i && spin_ready_i))
        else $error("j_ren_o high together with spin_ready_o");

    energy_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        energy_valid_i |=> !energy_valid_i)
        else $error("energy_valid_o high for more than one cycle");

    update_after_energy: assert property (@(posedge clk_i) disable iff (reset_i)
        best_update_i |-> $past(energy_valid_i))
        else $error("best_update_o without energy_valid_o one cycle before");

    flush_clears_best: assert property (@(posedge clk_i) disable iff (reset_i)
        flush_i |=> !best_valid_i)
        else $error("best_valid_o still high after flush_i");

endmodule

// ==== sim/tb_ising_macro.sv ====
/*
 * Directed testbench for the Ising energy engine.
 * The J memory model answers j_ren_o one cycle later. Expected energies
 * come from the full double sum over J plus the h term.
 */
`timescale 1ns/1ps

module tb_ising_macro
    import ising_pkg::*;
();

    localparam int TIMEOUT = 100;

    logic       clk_i = 1'b0;
    logic       reset_i;
    logic       flush_i;
    logic       spin_valid_i;
    spin_vec_t  spin_i;
    logic       spin_ready_o;
    logic       j_ren_o;
    j_addr_t    j_raddr_o;
    j_word_t    j_rdata_i = '0;
    hbias_vec_t hbias_i;
    logic       en_comparison_i;
    logic       energy_valid_o;
    energy_t    energy_o;
    logic       best_update_o;
    logic       best_valid_o;
    energy_t    best_energy_o;
    spin_vec_t  best_spin_o;

    j_word_t    j_mem [J_WORDS];
    integer     seed;
    int         error_count;
    int         timeout_count;
    // expected best store
    logic       exp_best_valid;
    int         exp_best_energy;
    spin_vec_t  exp_best_spin;

    ising_macro_top ising_macro_top_inst (.*);

    bind ising_macro_top ising_checker ising_checker_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .spin_ready_i   (spin_ready_o),
        .j_ren_i        (j_ren_o),
        .energy_valid_i (energy_valid_o),
        .best_update_i  (best_update_o),
        .best_valid_i   (best_valid_o)
    );

    always #5 clk_i = ~clk_i;

    // weight memory with one-cycle read latency
    always @(posedge clk_i) begin
        if (j_ren_o) begin
            j_rdata_i <= j_mem[j_raddr_o];
        end
    end

    function automatic int spin_sign(spin_vec_t s, int idx);
        return s[idx] ? 1 : -1;
    endfunction

    function automatic int ref_energy(spin_vec_t s);
        int total;
        total = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            total += int'($signed(hbias_i[i])) * spin_sign(s, i);
            for (int j = 0; j < NUM_SPIN; j++) begin
                total += int'($signed(j_mem[i / PARALLELISM][i % PARALLELISM][j]))
                         * spin_sign(s, i) * spin_sign(s, j);
            end
        end
        return total;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
        error_count++;
    endtask

    task automatic report_failure(string msg);
        $display("%s at %0t", msg, $time);
        error_count++;
    endtask

    task automatic finish_run();
        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic report_timeout(string what);
        $display("timed out waiting for %s at %0t", what, $time);
        timeout_count++;
        finish_run();
    endtask

    task automatic fill_random_weights();
        for (int w = 0; w < J_WORDS; w++) begin
            for (int p = 0; p < PARALLELISM; p++) begin
                for (int j = 0; j < NUM_SPIN; j++) begin
                    j_mem[w][p][j] = weight_t'($random(seed));
                end
            end
        end
        for (int i = 0; i < NUM_SPIN; i++) begin
            hbias_i[i] <= weight_t'($random(seed));
        end
    endtask

    // holds spin_valid_i until the vector is accepted
    task automatic send_spin(spin_vec_t s);
        int cycles;
        bit done;
        cycles = 0;
        done   = 1'b0;
        spin_i       <= s;
        spin_valid_i <= 1'b1;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
            done = spin_valid_i && spin_ready_o;
        end
        spin_valid_i <= 1'b0;
        if (!done)
            report_timeout("spin handshake");
    endtask

    // counts edges up to energy_valid_o while ready stays low
    // reads expected on the first J_WORDS edges, word by word
    task automatic wait_energy(input int start, output int cycles, output bit ok);
        logic exp_ren;
        cycles = start;
        ok     = 1'b0;
        while (!ok && cycles < start + TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
            ok = energy_valid_o;
            if (!ok && spin_ready_o)
                report_failure("spin_ready_o high while a computation is running");
            exp_ren = (cycles <= J_WORDS);
            if (j_ren_o !== exp_ren)
                report_mismatch("j_ren_o", 32'(j_ren_o), 32'(exp_ren));
            if (exp_ren && j_raddr_o !== j_addr_t'(cycles - 1))
                report_mismatch("j_raddr_o", 32'(j_raddr_o), cycles - 1);
        end
        if (!ok)
            report_timeout("energy_valid_o");
    endtask

    task automatic check_energy(spin_vec_t s, int cycles);
        int exp_e;
        exp_e = ref_energy(s);
        if (energy_o !== energy_t'(exp_e))
            report_mismatch("energy_o", 32'(energy_o), exp_e);
        if (cycles != J_WORDS + 2)
            report_failure($sformatf("energy_valid_o came %0d cycles after handshake", cycles));
        if (spin_ready_o !== 1'b1)
            report_mismatch("spin_ready_o", 32'(spin_ready_o), 1);
    endtask

    // sampled on the edge after energy_valid_o
    task automatic check_best(spin_vec_t s);
        int   exp_e;
        logic take;
        exp_e = ref_energy(s);
        take  = !exp_best_valid || (exp_e < exp_best_energy) || !en_comparison_i;
        if (best_update_o !== take)
            report_mismatch("best_update_o", 32'(best_update_o), 32'(take));
        if (take) begin
            exp_best_valid  = 1'b1;
            exp_best_energy = exp_e;
            exp_best_spin   = s;
        end
        if (best_valid_o !== exp_best_valid)
            report_mismatch("best_valid_o", 32'(best_valid_o), 32'(exp_best_valid));
        if (exp_best_valid && best_energy_o !== energy_t'(exp_best_energy))
            report_mismatch("best_energy_o", 32'(best_energy_o), exp_best_energy);
        if (exp_best_valid && best_spin_o !== exp_best_spin)
            report_mismatch("best_spin_o", 32'(best_spin_o), 32'(exp_best_spin));
    endtask

    task automatic run_config(spin_vec_t s);
        int cycles;
        bit ok;
        send_spin(s);
        wait_energy(0, cycles, ok);
        if (ok) begin
            check_energy(s, cycles);
            @(posedge clk_i);
            check_best(s);
        end
    endtask

    task automatic pulse_flush();
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        @(posedge clk_i);
        exp_best_valid = 1'b0;
        if (best_valid_o !== 1'b0)
            report_mismatch("best_valid_o", 32'(best_valid_o), 0);
    endtask

    task automatic test_single_energy();
        fill_random_weights();
        run_config(spin_vec_t'($random(seed)));
    endtask

    task automatic test_uniform();
        spin_vec_t spins;
        for (int w = 0; w < J_WORDS; w++) begin
            j_mem[w] = {(PARALLELISM * NUM_SPIN){weight_t'(1)}};
        end
        hbias_i <= '0;
        spins = '1;
        run_config(spins);
        if (energy_o !== energy_t'(NUM_SPIN * NUM_SPIN))
            report_mismatch("energy_o", 32'(energy_o), NUM_SPIN * NUM_SPIN);
        // one spin down leaves a field sum of NUM_SPIN-2
        spins[0] = 1'b0;
        run_config(spins);
        if (energy_o !== energy_t'((NUM_SPIN - 2) * (NUM_SPIN - 2)))
            report_mismatch("energy_o", 32'(energy_o), (NUM_SPIN - 2) * (NUM_SPIN - 2));
    endtask

    task automatic test_best_tracking();
        spin_vec_t s;
        int        min_e;
        fill_random_weights();
        pulse_flush();
        min_e = 1 << 30;
        repeat (8) begin
            s = spin_vec_t'($random(seed));
            if (ref_energy(s) < min_e)
                min_e = ref_energy(s);
            run_config(s);
        end
        if (best_energy_o !== energy_t'(min_e))
            report_mismatch("best_energy_o", 32'(best_energy_o), min_e);
    endtask

    task automatic test_comparison_off();
        en_comparison_i <= 1'b0;
        repeat (4) begin
            run_config(spin_vec_t'($random(seed)));
        end
        en_comparison_i <= 1'b1;
    endtask

    task automatic test_flush();
        spin_vec_t s;
        spin_vec_t low;
        spin_vec_t high;
        s = spin_vec_t'($random(seed));
        // all spins inverted keeps the J term and negates the h term
        low  = (ref_energy(s) <= ref_energy(~s)) ? s : ~s;
        high = ~low;
        run_config(low);
        run_config(high);
        pulse_flush();
        run_config(high);
        if (best_energy_o !== energy_t'(ref_energy(high)))
            report_mismatch("best_energy_o", 32'(best_energy_o), ref_energy(high));
    endtask

    task automatic test_back_pressure();
        spin_vec_t first;
        spin_vec_t second;
        int        cycles;
        bit        ok;
        first  = spin_vec_t'($random(seed));
        second = spin_vec_t'($random(seed));
        send_spin(first);
        // second vector held while the first one runs
        spin_i       <= second;
        spin_valid_i <= 1'b1;
        wait_energy(0, cycles, ok);
        if (ok) begin
            check_energy(first, cycles);
            spin_valid_i <= 1'b0;
            @(posedge clk_i);
            check_best(first);
            wait_energy(1, cycles, ok);
            if (ok) begin
                check_energy(second, cycles);
                @(posedge clk_i);
                check_best(second);
            end
        end
    endtask

    initial begin
        seed            = 51152;
        error_count     = 0;
        timeout_count   = 0;
        exp_best_valid  = 1'b0;
        exp_best_energy = 0;
        exp_best_spin   = '0;
        reset_i         = 1'b1;
        flush_i         = 1'b0;
        spin_valid_i    = 1'b0;
        spin_i          = '0;
        hbias_i         = '0;
        en_comparison_i = 1'b1;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        @(posedge clk_i);
        if (spin_ready_o !== 1'b1 || j_ren_o !== 1'b0 || energy_valid_o !== 1'b0 ||
            best_update_o !== 1'b0 || best_valid_o !== 1'b0)
            report_failure("outputs not in their reset state");
        test_single_energy();
        test_uniform();
        test_best_tracking();
        test_comparison_off();
        test_flush();
        test_back_pressure();
        finish_run();
    end

endmodule

// ==== flist.f ====
+incdir+hw
hw/ising_pkg.sv
hw/pipe_pkg.sv
hw/weight_fetch.sv
hw/energy_accumulator.sv
hw/best_spin_tracker.sv
hw/ising_macro_top.sv
sim/ising_checker.sv
sim/tb_ising_macro.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the Ising engine testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module tb_ising_macro \
    -Mdir obj_dir -o tb_ising_macro
./obj_dir/tb_ising_macro | tee sim.log
if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
